// File: bench/mport_stimulus.txt
# op addr1 din1 rd2a_addr rd2b_addr exp_dout1 exp_rd2a exp_rd2b (hex, address = row*8 + bank)
# op: W write, R1 port 1 read, RR port 2a/2b read, WR write plus port 2a/2b read, I idle
R1 005 0000 000 000 0000 0000 0000
RR 000 0000 011 019 0000 0000 0000
W  00a 1234 000 000 0000 0000 0000
R1 00a 0000 000 000 1234 0000 0000
W  013 beef 000 000 0000 0000 0000
RR 000 0000 013 00a 0000 beef 1234
W  01b 5a5a 000 000 0000 0000 0000
RR 000 0000 013 01b 0000 beef 5a5a
W  022 c3c3 000 000 0000 0000 0000
I  000 0000 000 000 0000 0000 0000
RR 000 0000 02a 022 0000 0000 c3c3
W  030 1111 000 000 0000 0000 0000
W  031 2222 000 000 0000 0000 0000
W  032 3333 000 000 0000 0000 0000
WR 030 4444 000 030 0000 0000 1111
RR 000 0000 000 030 0000 0000 4444
R1 030 0000 000 000 4444 0000 0000
RR 000 0000 031 032 0000 2222 3333
RR 000 0000 029 031 0000 0000 2222
I  000 0000 000 000 0000 0000 0000

// File: bench/tb_mport.sv
module tb_mport
  import mport_addr_pkg::*;
  import mport_data_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  logic   clk;
  logic   rstvld;
  logic   ready;
  logic   wr_en;
  logic   rd1_en;
  vaddr_t addr1;
  data_t  din1;
  logic   rd1_vld;
  data_t  dout1;
  logic   rd2a_en;
  vaddr_t rd2a_addr;
  logic   rd2a_vld;
  data_t  rd2a_dout;
  logic   rd2b_en;
  vaddr_t rd2b_addr;
  logic   rd2b_vld;
  data_t  rd2b_dout;

  string            op_list [$];
  logic [0:6][31:0] fld_list [$];  // addr1 din1 rd2a rd2b exp1 exp2a exp2b
  data_t            exp1_q [$];
  data_t            exp2a_q [$];
  data_t            exp2b_q [$];
  int               due1_q [$];
  int               due2a_q [$];
  int               due2b_q [$];
  int               cycle_cnt;
  int               cycle_limit;
  int               err_cnt;

  mport_top uut (
    .clk, .rstvld, .ready, .wr_en, .rd1_en, .addr1, .din1, .rd1_vld, .dout1,
    .rd2a_en, .rd2a_addr, .rd2a_vld, .rd2a_dout,
    .rd2b_en, .rd2b_addr, .rd2b_vld, .rd2b_dout
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    err_cnt++;
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      stop_with_failure("value mismatch");
    end
  endtask

  task automatic load_stimulus();
    int               fd;
    int               n;
    string            line;
    string            op;
    logic [0:6][31:0] f;
    fd = $fopen("bench/mport_stimulus.txt", "r");
    if (fd == 0) begin
      stop_with_failure("Could not open the stimulus file bench/mport_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != 8'h23) begin  // Skip comments
          n = $sscanf(line, "%s %h %h %h %h %h %h %h", op, f[0], f[1], f[2], f[3],
                      f[4], f[5], f[6]);
          if (n == 8) begin
            op_list.push_back(op);
            fld_list.push_back(f);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////
  // Timeout and result monitor
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit)
      stop_with_failure("Timeout: the run took more cycles than the stimulus needs");
  end

  // Sampled at the falling edge, away from the DUT's updates
  always @(negedge clk) begin
    if (rd1_vld) begin
      if (exp1_q.size() == 0)
        stop_with_failure("Port 1 returned data with no read pending");
      else begin
        check_value("rd1_vld cycle", 32'(cycle_cnt), 32'(due1_q.pop_front()));
        check_value("dout1", 32'(dout1), 32'(exp1_q.pop_front()));
      end
    end
    if (rd2a_vld) begin
      if (exp2a_q.size() == 0)
        stop_with_failure("Port 2a returned data with no read pending");
      else begin
        check_value("rd2a_vld cycle", 32'(cycle_cnt), 32'(due2a_q.pop_front()));
        check_value("rd2a_dout", 32'(rd2a_dout), 32'(exp2a_q.pop_front()));
      end
    end
    if (rd2b_vld) begin
      if (exp2b_q.size() == 0)
        stop_with_failure("Port 2b returned data with no read pending");
      else begin
        check_value("rd2b_vld cycle", 32'(cycle_cnt), 32'(due2b_q.pop_front()));
        check_value("rd2b_dout", 32'(rd2b_dout), 32'(exp2b_q.pop_front()));
      end
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int cycles;
    clk         = 1'b0;
    rstvld      = 1'b1;
    wr_en       = 1'b0;
    rd1_en      = 1'b0;
    addr1       = '0;
    din1        = '0;
    rd2a_en     = 1'b0;
    rd2a_addr   = '0;
    rd2b_en     = 1'b0;
    rd2b_addr   = '0;
    cycle_cnt   = 0;
    cycle_limit = 1000;
    err_cnt     = 0;

    load_stimulus();
    cycle_limit = 10 + 67 + op_list.size() + 10;

    repeat (10) @(posedge clk);
    #1 rstvld = 1'b0;

    cycles = 0;
    do begin  // Init sweep, drain, then ready
      @(posedge clk);
      cycles++;
      #1;
    end while (!ready);
    check_value("ready delay", 32'(cycles), 32'd67);

    foreach (op_list[i]) begin
      wr_en     = (op_list[i] == "W") || (op_list[i] == "WR");
      rd1_en    = (op_list[i] == "R1");
      rd2a_en   = (op_list[i] == "RR") || (op_list[i] == "WR");
      rd2b_en   = rd2a_en;
      addr1     = vaddr_t'(fld_list[i][0]);
      din1      = data_t'(fld_list[i][1]);
      rd2a_addr = vaddr_t'(fld_list[i][2]);
      rd2b_addr = vaddr_t'(fld_list[i][3]);
      // Accepted at the next edge, result seen two edges from now
      if (rd1_en) begin
        exp1_q.push_back(data_t'(fld_list[i][4]));
        due1_q.push_back(cycle_cnt + 2);
      end
      if (rd2a_en) begin
        exp2a_q.push_back(data_t'(fld_list[i][5]));
        exp2b_q.push_back(data_t'(fld_list[i][6]));
        due2a_q.push_back(cycle_cnt + 2);
        due2b_q.push_back(cycle_cnt + 2);
      end
      @(posedge clk);
      #1;
    end
    wr_en   = 1'b0;
    rd1_en  = 1'b0;
    rd2a_en = 1'b0;
    rd2b_en = 1'b0;

    while (exp1_q.size() + exp2a_q.size() + exp2b_q.size() != 0)
      @(posedge clk);
    repeat (2) @(posedge clk);

    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: design/bank_sram.sv
`include "mport_settings.svh"

module bank_sram
  import mport_addr_pkg::*;
  import mport_data_pkg::*;
(
  input  logic  clk,
  input  logic  we1,
  input  logic  re1,
  input  row_t  row1,
  input  data_t din1,
  output data_t dout1,
  input  logic  re2,
  input  row_t  row2,
  output data_t dout2
);

  localparam int D = `MPORT_SRAM_DELAY;

  data_t mem [0:`MPORT_NUMVROW-1];
  data_t pipe1 [0:D-1];
  data_t pipe2 [0:D-1];

  always_ff @(posedge clk) begin
    if (we1)
      mem[row1] <= din1;
    if (re1)
      pipe1[0] <= mem[row1];  // Old word on a same-cycle write
    if (re2)
      pipe2[0] <= mem[row2];
    for (int i = 1; i < D; i++) begin
      pipe1[i] <= pipe1[i-1];
      pipe2[i] <= pipe2[i-1];
    end
  end

  assign dout1 = pipe1[D-1];
  assign dout2 = pipe2[D-1];

  a_port1_rw: assert property (@(posedge clk) !(we1 && re1));

endmodule

// File: design/init_sequencer.sv
`include "mport_settings.svh"

module init_sequencer
  import mport_addr_pkg::*;
  import mport_data_pkg::*;
(
  input  logic clk,
  input  logic rstvld,
  output logic init_busy,
  output row_t init_row,
  output logic ready
);

  init_state_t state;
  row_t        row_cnt;
  logic [1:0]  drain_cnt;

  always_ff @(posedge clk) begin
    if (rstvld) begin
      state     <= INIT_SWEEP;
      row_cnt   <= '0;
      drain_cnt <= '0;
      ready     <= 1'b0;
    end else begin
      case (state)
        INIT_SWEEP: begin
          row_cnt <= row_cnt + 1'b1;
          if (row_cnt == row_t'(`MPORT_NUMVROW - 1))
            state <= INIT_DRAIN;
        end
        INIT_DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == 2'(`MPORT_SRAM_DELAY - 1))
            state <= INIT_DONE;
        end
        default: ready <= 1'b1;  // One cycle after the drain
      endcase
    end
  end

  assign init_busy = (state == INIT_SWEEP);
  assign init_row  = row_cnt;

endmodule

// File: design/mport_addr_pkg.sv
`include "mport_settings.svh"

package mport_addr_pkg;

  // Port address, bank index in the low bits, row above it
  typedef logic [`MPORT_BITADDR-1:0] vaddr_t;

  // Bank index
  typedef logic [`MPORT_BITVBNK-1:0] bank_t;

  // Row within one bank
  typedef logic [`MPORT_BITVROW-1:0] row_t;

endpackage

// File: design/mport_data_pkg.sv
`include "mport_settings.svh"

package mport_data_pkg;

  // One memory word
  typedef logic [`MPORT_WIDTH-1:0] data_t;

  // One enable bit per data bank
  typedef logic [`MPORT_NUMVBNK-1:0] bank_mask_t;

  typedef enum logic [1:0] {
    INIT_SWEEP,  // Zero one row per cycle
    INIT_DRAIN,  // Wait for the SRAM pipe to empty
    INIT_DONE
  } init_state_t;

endpackage

// File: design/mport_settings.svh
`ifndef MPORT_SETTINGS_SVH
`define MPORT_SETTINGS_SVH

////////////////////////////////////////
// Memory geometry
////////////////////////////////////////

`define MPORT_WIDTH      16  // Bits per word
`define MPORT_NUMVBNK    8   // Data banks, parity bank not counted
`define MPORT_BITVBNK    3
`define MPORT_NUMVROW    64  // Rows per bank
`define MPORT_BITVROW    6
`define MPORT_BITADDR    9   // Bank bits plus row bits

////////////////////////////////////////
// SRAM timing
////////////////////////////////////////

`define MPORT_SRAM_DELAY 2   // Read enable to data

`endif

// File: design/mport_top.sv
`include "mport_settings.svh"

module mport_top
  import mport_addr_pkg::*;
  import mport_data_pkg::*;
(
  input  logic   clk,
  input  logic   rstvld,
  output logic   ready,
  input  logic   wr_en,
  input  logic   rd1_en,
  input  vaddr_t addr1,
  input  data_t  din1,
  output logic   rd1_vld,
  output data_t  dout1,
  input  logic   rd2a_en,
  input  vaddr_t rd2a_addr,
  output logic   rd2a_vld,
  output data_t  rd2a_dout,
  input  logic   rd2b_en,
  input  vaddr_t rd2b_addr,
  output logic   rd2b_vld,
  output data_t  rd2b_dout
);

  logic       init_busy;
  row_t       init_row;
  bank_mask_t p1_we;
  bank_mask_t p1_re;
  row_t       p1_row;
  data_t      p1_din;
  bank_mask_t p2_re;
  row_t       p2a_row;
  row_t       p2b_row;
  logic       wr_go;
  row_t       wr_row;
  logic       x_re;
  row_t       cf_row;
  row_t       cf_row_dly;
  logic       wr_dly;
  bank_t      wr_bank_dly;
  row_t       wr_row_dly;
  data_t      din_dly;
  bank_t      rd1_bank_dly;
  bank_t      rd2a_bank_dly;
  bank_t      rd2b_bank_dly;
  logic       cf_dly;
  logic       x_we;
  row_t       x_row;
  data_t      x_din;
  data_t      x_dout;
  logic       fwd_vld;
  data_t      fwd_data;
  data_t      p1_dout [0:`MPORT_NUMVBNK-1];
  data_t      p2_dout [0:`MPORT_NUMVBNK-1];

  init_sequencer u_init (
    .clk, .rstvld, .init_busy, .init_row, .ready
  );

  port_scheduler u_sched (
    .clk, .rstvld, .ready, .init_busy, .init_row,
    .wr_en, .rd1_en, .addr1, .din1, .rd2a_en, .rd2a_addr, .rd2b_en, .rd2b_addr,
    .p1_we, .p1_re, .p1_row, .p1_din, .p2_re, .p2a_row, .p2b_row,
    .wr_go, .wr_row, .x_re, .cf_row, .cf_row_dly,
    .wr_dly, .wr_bank_dly, .wr_row_dly, .din_dly,
    .rd1_vld, .rd2a_vld, .rd2b_vld, .rd1_bank_dly, .rd2a_bank_dly, .rd2b_bank_dly, .cf_dly
  );

  // Port 2a bank takes its own row, every other bank follows 2b
  for (genvar i = 0; i < `MPORT_NUMVBNK; i++) begin : g_bank
    bank_sram u_bank (
      .clk,
      .we1   (p1_we[i]),
      .re1   (p1_re[i]),
      .row1  (p1_row),
      .din1  (p1_din),
      .dout1 (p1_dout[i]),
      .re2   (p2_re[i]),
      .row2  ((rd2a_addr[`MPORT_BITVBNK-1:0] == bank_t'(i)) ? p2a_row : p2b_row),
      .dout2 (p2_dout[i])
    );
  end

  bank_sram u_xbank (
    .clk,
    .we1   (x_we),
    .re1   (1'b0),    // Parity port 1 only writes
    .row1  (x_row),
    .din1  (x_din),
    .dout1 (),
    .re2   (x_re),
    .row2  (cf_row),
    .dout2 (x_dout)
  );

  parity_engine u_parity (
    .clk, .rstvld, .init_busy, .init_row, .wr_go, .wr_row,
    .wr_dly, .wr_bank_dly, .wr_row_dly, .din_dly, .p1_dout,
    .cf_row, .cf_row_dly, .x_we, .x_row, .x_din, .fwd_vld, .fwd_data
  );

  read_assembler u_rdasm (
    .rd1_bank_dly, .rd2a_bank_dly, .rd2b_bank_dly, .cf_dly,
    .p1_dout, .p2_dout, .x_dout, .fwd_vld, .fwd_data,
    .dout1, .rd2a_dout, .rd2b_dout
  );

endmodule

// File: design/parity_engine.sv
`include "mport_settings.svh"

module parity_engine
  import mport_addr_pkg::*;
  import mport_data_pkg::*;
(
  input  logic  clk,
  input  logic  rstvld,
  input  logic  init_busy,
  input  row_t  init_row,
  input  logic  wr_go,
  input  row_t  wr_row,
  input  logic  wr_dly,
  input  bank_t wr_bank_dly,
  input  row_t  wr_row_dly,
  input  data_t din_dly,
  input  data_t p1_dout [0:`MPORT_NUMVBNK-1],
  input  row_t  cf_row,
  input  row_t  cf_row_dly,
  output logic  x_we,
  output row_t  x_row,
  output data_t x_din,
  output logic  fwd_vld,
  output data_t fwd_data
);

  logic  hit0, hit1;
  logic  fwd_v0, fwd_v1;
  data_t fwd_d0, fwd_d1;

  ////////////////////////////////////////
  // New parity word
  ////////////////////////////////////////

  always_comb begin
    x_din = '0;
    if (!init_busy) begin
      for (int i = 0; i < `MPORT_NUMVBNK; i++) begin
        if (bank_t'(i) == wr_bank_dly)
          x_din = x_din ^ din_dly;  // New word replaces the target bank
        else
          x_din = x_din ^ p1_dout[i];
      end
    end
  end

  assign x_we  = init_busy || wr_dly;
  assign x_row = init_busy ? init_row : wr_row_dly;

  ////////////////////////////////////////
  // Forwarding to conflicting reads
  ////////////////////////////////////////

  assign hit0 = x_we && (x_row == cf_row);
  assign hit1 = x_we && (x_row == cf_row_dly);

  always_ff @(posedge clk) begin
    if (rstvld) begin
      fwd_v0 <= 1'b0;
      fwd_v1 <= 1'b0;
    end else begin
      fwd_v0 <= hit0;
      fwd_v1 <= hit1 || fwd_v0;
    end
  end

  always_ff @(posedge clk) begin
    fwd_d0 <= hit0 ? x_din : '0;
    fwd_d1 <= hit1 ? x_din : fwd_d0;  // Later write wins
  end

  assign fwd_vld  = fwd_v1;
  assign fwd_data = fwd_d1;

  // Parity lands on the written row one SRAM latency after acceptance
  a_parity_wr: assert property (@(posedge clk) disable iff (rstvld)
    wr_go |-> ##2 (x_we && (x_row == $past(wr_row, 2))));

endmodule

// File: design/port_scheduler.sv
`include "mport_settings.svh"

module port_scheduler
  import mport_addr_pkg::*;
  import mport_data_pkg::*;
(
  input  logic       clk,
  input  logic       rstvld,
  input  logic       ready,
  input  logic       init_busy,
  input  row_t       init_row,
  input  logic       wr_en,
  input  logic       rd1_en,
  input  vaddr_t     addr1,
  input  data_t      din1,
  input  logic       rd2a_en,
  input  vaddr_t     rd2a_addr,
  input  logic       rd2b_en,
  input  vaddr_t     rd2b_addr,
  output bank_mask_t p1_we,
  output bank_mask_t p1_re,
  output row_t       p1_row,
  output data_t      p1_din,
  output bank_mask_t p2_re,
  output row_t       p2a_row,
  output row_t       p2b_row,
  output logic       wr_go,
  output row_t       wr_row,
  output logic       x_re,
  output row_t       cf_row,
  output row_t       cf_row_dly,
  output logic       wr_dly,
  output bank_t      wr_bank_dly,
  output row_t       wr_row_dly,
  output data_t      din_dly,
  output logic       rd1_vld,
  output logic       rd2a_vld,
  output logic       rd2b_vld,
  output bank_t      rd1_bank_dly,
  output bank_t      rd2a_bank_dly,
  output bank_t      rd2b_bank_dly,
  output logic       cf_dly
);

  localparam int D = `MPORT_SRAM_DELAY;

  logic       rd1_go, rd2a_go, rd2b_go, cf;
  bank_t      bank1, bank2a, bank2b;
  row_t       row1, row2a, row2b;
  bank_mask_t one1, one2a, one2b;

  logic [D-1:0] wr_q, rd1_q, rd2a_q, rd2b_q, cf_q;
  bank_t        bank1_q [0:D-1];
  bank_t        bank2a_q [0:D-1];
  bank_t        bank2b_q [0:D-1];
  row_t         row1_q [0:D-1];
  row_t         cfrow_q;
  data_t        din_q [0:D-1];

  ////////////////////////////////////////
  // Accept and decode
  ////////////////////////////////////////

  assign wr_go   = wr_en && ready;
  assign rd1_go  = rd1_en && ready;
  assign rd2a_go = rd2a_en && ready;
  assign rd2b_go = rd2b_en && ready;

  assign {row1, bank1}   = addr1;
  assign {row2a, bank2a} = rd2a_addr;
  assign {row2b, bank2b} = rd2b_addr;

  assign one1  = bank_mask_t'(1) << bank1;
  assign one2a = bank_mask_t'(1) << bank2a;
  assign one2b = bank_mask_t'(1) << bank2b;

  assign cf = rd2a_go && rd2b_go && (bank2a == bank2b);  // 2b must rebuild

  always_comb begin
    p1_we  = '0;
    p1_re  = '0;
    p1_row = row1;
    if (init_busy) begin
      p1_we  = '1;
      p1_row = init_row;
    end else if (wr_go) begin
      p1_we = one1;
      p1_re = ~one1;  // Old words of the row feed the parity
    end else if (rd1_go) begin
      p1_re = one1;
    end
  end

  assign p1_din = init_busy ? '0 : din1;

  always_comb begin
    p2_re = '0;
    if (rd2a_go)
      p2_re = one2a;
    if (cf)
      p2_re = p2_re | ~one2b;
    else if (rd2b_go)
      p2_re = p2_re | one2b;
  end

  assign p2a_row = rd2a_go ? row2a : row2b;
  assign p2b_row = row2b;
  assign x_re    = cf;
  assign cf_row  = row2b;
  assign wr_row  = row1;

  ////////////////////////////////////////
  // Delay line, matches SRAM latency
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rstvld) begin
      wr_q   <= '0;
      rd1_q  <= '0;
      rd2a_q <= '0;
      rd2b_q <= '0;
      cf_q   <= '0;
    end else begin
      wr_q   <= {wr_q[D-2:0], wr_go};
      rd1_q  <= {rd1_q[D-2:0], rd1_go};
      rd2a_q <= {rd2a_q[D-2:0], rd2a_go};
      rd2b_q <= {rd2b_q[D-2:0], rd2b_go};
      cf_q   <= {cf_q[D-2:0], cf};
    end
  end

  always_ff @(posedge clk) begin
    bank1_q[0]  <= bank1;
    bank2a_q[0] <= bank2a;
    bank2b_q[0] <= bank2b;
    row1_q[0]   <= row1;
    cfrow_q     <= row2b;
    din_q[0]    <= din1;
    for (int i = 1; i < D; i++) begin
      bank1_q[i]  <= bank1_q[i-1];
      bank2a_q[i] <= bank2a_q[i-1];
      bank2b_q[i] <= bank2b_q[i-1];
      row1_q[i]   <= row1_q[i-1];
      din_q[i]    <= din_q[i-1];
    end
  end

  assign wr_dly        = wr_q[D-1];
  assign wr_bank_dly   = bank1_q[D-1];
  assign wr_row_dly    = row1_q[D-1];
  assign din_dly       = din_q[D-1];
  assign cf_row_dly    = cfrow_q;  // Read accepted one cycle ago
  assign rd1_vld       = rd1_q[D-1];
  assign rd2a_vld      = rd2a_q[D-1];
  assign rd2b_vld      = rd2b_q[D-1];
  assign rd1_bank_dly  = bank1_q[D-1];
  assign rd2a_bank_dly = bank2a_q[D-1];
  assign rd2b_bank_dly = bank2b_q[D-1];
  assign cf_dly        = cf_q[D-1];

  // Port 1 serves one request per cycle
  a_port1_excl: assert property (@(posedge clk) disable iff (rstvld)
    ready |-> !(wr_en && rd1_en));

endmodule

// File: design/read_assembler.sv
`include "mport_settings.svh"

module read_assembler
  import mport_addr_pkg::*;
  import mport_data_pkg::*;
(
  input  bank_t rd1_bank_dly,
  input  bank_t rd2a_bank_dly,
  input  bank_t rd2b_bank_dly,
  input  logic  cf_dly,
  input  data_t p1_dout [0:`MPORT_NUMVBNK-1],
  input  data_t p2_dout [0:`MPORT_NUMVBNK-1],
  input  data_t x_dout,
  input  logic  fwd_vld,
  input  data_t fwd_data,
  output data_t dout1,
  output data_t rd2a_dout,
  output data_t rd2b_dout
);

  data_t parity_word;

  ////////////////////////////////////////
  // Direct reads
  ////////////////////////////////////////

  assign dout1     = p1_dout[rd1_bank_dly];
  assign rd2a_dout = p2_dout[rd2a_bank_dly];

  ////////////////////////////////////////
  // Port 2b, direct or rebuilt
  ////////////////////////////////////////

  // Parity bank may be stale by up to two writes
  assign parity_word = fwd_vld ? fwd_data : x_dout;

  always_comb begin
    data_t acc;
    acc = parity_word;
    for (int i = 0; i < `MPORT_NUMVBNK; i++) begin
      if (bank_t'(i) != rd2b_bank_dly)
        acc = acc ^ p2_dout[i];
    end
    // Bank busy with 2a, so fold the rest of the row
    if (cf_dly)
      rd2b_dout = acc;
    else
      rd2b_dout = p2_dout[rd2b_bank_dly];
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_mport -f src.f -o sim_mport

if ! ./obj_dir/sim_mport > sim.log 2>&1; then
  cat sim.log
  exit 1
fi
cat sim.log

if grep -q "^Test passed$" sim.log; then
  exit 0
else
  exit 1
fi

// File: src.f
+incdir+design
design/mport_addr_pkg.sv
design/mport_data_pkg.sv
design/init_sequencer.sv
design/port_scheduler.sv
design/bank_sram.sv
design/parity_engine.sv
design/read_assembler.sv
design/mport_top.sv
bench/tb_mport.sv
